// File: common/rx_macros.svh
// widths, word address map, latency and reset values of the rx endpoint
// addresses are word addresses and the data memory latency must be at least 1
`ifndef RX_MACROS_SVH
`define RX_MACROS_SVH

`define RX_DATA_WIDTH      32
`define RX_MASK_WIDTH      (`RX_DATA_WIDTH / 8)
`define RX_ADDR_WIDTH      16
`define RX_DMEM_WORDS      256
`define RX_DMEM_ADDR_WIDTH 8
`define RX_PC_WIDTH        6
`define RX_X_WIDTH         4
`define RX_Y_WIDTH         4

// control space starts at bit 13, register index in the bits below
`define RX_CSR_BASE        16'h2000
`define RX_DMEM_LAT        2

`define RX_FREEZE_INIT     1
`define RX_TGO_X_INIT      0
`define RX_TGO_Y_INIT      1
`define RX_PC_INIT         0
`define RX_INVALID_DATA    32'hdeadbeef

`endif

// File: common/rx_types_pkg.sv
// vector types with a meaning on the rx endpoint
// widths come from the macro header
`include "rx_macros.svh"

package rx_types_pkg;

  // network payload
  typedef logic [`RX_DATA_WIDTH-1:0] data_t;
  typedef logic [`RX_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`RX_MASK_WIDTH-1:0] mask_t;

  // local storage indices
  typedef logic [`RX_DMEM_ADDR_WIDTH-1:0] dmem_addr_t;
  typedef logic [`RX_PC_WIDTH-1:0] pc_t;

  // tile coordinates
  typedef logic [`RX_X_WIDTH-1:0] coord_x_t;
  typedef logic [`RX_Y_WIDTH-1:0] coord_y_t;

endpackage

// File: common/rx_ctrl_pkg.sv
// encodings for address regions, csr index, controller state and response source
// csr_idx_e follows the word offset inside control space

package rx_ctrl_pkg;

  typedef enum logic [1:0] {
    REG_DMEM,
    REG_ICACHE,
    REG_CSR,
    REG_INVALID
  } region_e;

  typedef enum logic [1:0] {
    CSR_FREEZE,
    CSR_TGO_X,
    CSR_TGO_Y,
    CSR_PC_INIT
  } csr_idx_e;

  typedef enum logic {
    ST_IDLE,
    ST_DMEM_WAIT
  } rx_state_e;

  typedef enum logic [2:0] {
    RS_NONE,
    RS_ZERO,
    RS_DMEM,
    RS_CSR,
    RS_INVALID
  } resp_sel_e;

endpackage

// File: design/rx_addr_decode.sv
// purely combinational, regions are one-hot bit tests with upper bits zero
// control space indices above 3 are reported as invalid
`include "rx_macros.svh"

module rx_addr_decode (
  input  rx_types_pkg::addr_t     addr_i,
  output rx_ctrl_pkg::region_e    region_o,
  output rx_ctrl_pkg::csr_idx_e   csr_idx_o
);

  localparam int CSR_BIT = $clog2(`RX_CSR_BASE);
  localparam int DMEM_BIT = `RX_DMEM_ADDR_WIDTH;
  localparam int ICACHE_BIT = `RX_PC_WIDTH;

  localparam rx_types_pkg::addr_t CSR_BASE = `RX_CSR_BASE;

  logic is_dmem;
  logic is_icache;
  logic is_csr_space;
  logic is_csr;

  assign is_dmem = addr_i[DMEM_BIT] & (addr_i[`RX_ADDR_WIDTH-1:DMEM_BIT+1] == '0);
  assign is_icache = addr_i[ICACHE_BIT] & (addr_i[`RX_ADDR_WIDTH-1:ICACHE_BIT+1] == '0);

  // bit 13 set, bits 15:14 clear
  assign is_csr_space = (addr_i[`RX_ADDR_WIDTH-1:CSR_BIT] == CSR_BASE[`RX_ADDR_WIDTH-1:CSR_BIT]);
  // only four registers exist
  assign is_csr = is_csr_space & (addr_i[CSR_BIT-1:2] == '0);

  assign csr_idx_o = rx_ctrl_pkg::csr_idx_e'(addr_i[1:0]);

  always_comb begin
    if (is_dmem) begin
      region_o = rx_ctrl_pkg::REG_DMEM;
    end else if (is_icache) begin
      region_o = rx_ctrl_pkg::REG_ICACHE;
    end else if (is_csr) begin
      region_o = rx_ctrl_pkg::REG_CSR;
    end else begin
      region_o = rx_ctrl_pkg::REG_INVALID;
    end
  end

endmodule

// File: design/csr_regs.sv
// freeze, tgo_x, tgo_y and pc_init registers, written one at a time
// pc_init is written from data bit 2 up and read back shifted left by two
`include "rx_macros.svh"

module csr_regs (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     we_i,
  input  rx_ctrl_pkg::csr_idx_e    idx_i,
  input  rx_types_pkg::data_t      wdata_i,
  output rx_types_pkg::data_t      rdata_o,
  output logic                     freeze_o,
  output rx_types_pkg::coord_x_t   tgo_x_o,
  output rx_types_pkg::coord_y_t   tgo_y_o,
  output rx_types_pkg::pc_t        pc_init_val_o
);

  logic                   freeze_r;
  rx_types_pkg::coord_x_t tgo_x_r;
  rx_types_pkg::coord_y_t tgo_y_r;
  rx_types_pkg::pc_t      pc_init_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      freeze_r  <= 1'(`RX_FREEZE_INIT);
      tgo_x_r   <= `RX_X_WIDTH'(`RX_TGO_X_INIT);
      tgo_y_r   <= `RX_Y_WIDTH'(`RX_TGO_Y_INIT);
      pc_init_r <= `RX_PC_WIDTH'(`RX_PC_INIT);
    end else if (we_i) begin
      case (idx_i)
        rx_ctrl_pkg::CSR_FREEZE:  freeze_r  <= wdata_i[0];
        rx_ctrl_pkg::CSR_TGO_X:   tgo_x_r   <= wdata_i[`RX_X_WIDTH-1:0];
        rx_ctrl_pkg::CSR_TGO_Y:   tgo_y_r   <= wdata_i[`RX_Y_WIDTH-1:0];
        rx_ctrl_pkg::CSR_PC_INIT: pc_init_r <= wdata_i[2 +: `RX_PC_WIDTH];
        default: ;
      endcase
    end
  end

  // read word, zero extended
  always_comb begin
    rdata_o = '0;
    case (idx_i)
      rx_ctrl_pkg::CSR_FREEZE:  rdata_o[0] = freeze_r;
      rx_ctrl_pkg::CSR_TGO_X:   rdata_o[`RX_X_WIDTH-1:0] = tgo_x_r;
      rx_ctrl_pkg::CSR_TGO_Y:   rdata_o[`RX_Y_WIDTH-1:0] = tgo_y_r;
      rx_ctrl_pkg::CSR_PC_INIT: rdata_o[2 +: `RX_PC_WIDTH] = pc_init_r;
      default: ;
    endcase
  end

  assign freeze_o      = freeze_r;
  assign tgo_x_o       = tgo_x_r;
  assign tgo_y_o       = tgo_y_r;
  assign pc_init_val_o = pc_init_r;

endmodule

// File: dmem/dmem_bank.sv
// single port data memory with byte write mask and a registered read word
// rdata_o holds the last read until the next read
`include "rx_macros.svh"

module dmem_bank (
  input  logic                      clk_i,
  input  logic                      v_i,
  input  logic                      w_i,
  input  rx_types_pkg::dmem_addr_t  addr_i,
  input  rx_types_pkg::mask_t       mask_i,
  input  rx_types_pkg::data_t       wdata_i,
  output rx_types_pkg::data_t       rdata_o
);

  rx_types_pkg::data_t mem [`RX_DMEM_WORDS];

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (w_i) begin
        for (int b = 0; b < `RX_MASK_WIDTH; b++) begin
          if (mask_i[b]) begin
            mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

  // a write with no byte enabled is a requester bug
  a_write_mask_nonzero: assert property (
    @(posedge clk_i) (v_i && w_i) |-> (mask_i != '0)
  ) else $error("dmem write with empty byte mask");

endmodule

// File: design/icache_store.sv
// instruction array, written from the network side only
// fetch read is asynchronous, so a write is visible the cycle after its edge
`include "rx_macros.svh"

module icache_store (
  input  logic                 clk_i,
  input  logic                 we_i,
  input  rx_types_pkg::pc_t    wpc_i,
  input  rx_types_pkg::data_t  winstr_i,
  input  rx_types_pkg::pc_t    fetch_pc_i,
  output rx_types_pkg::data_t  fetch_instr_o
);

  localparam int ENTRIES = 2 ** `RX_PC_WIDTH;

  rx_types_pkg::data_t instr_mem [ENTRIES];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      instr_mem[wpc_i] <= winstr_i;
    end
  end

  // core side fetch
  assign fetch_instr_o = instr_mem[fetch_pc_i];

endmodule

// File: design/rx_wait_timer.sv
// down counter for the data memory latency, loaded with RX_DMEM_LAT on start
// done_o marks the last wait cycle
`include "rx_macros.svh"

module rx_wait_timer (
  input  logic clk_i,
  input  logic reset_i,
  input  logic start_i,
  output logic done_o
);

  localparam int CNT_W = $clog2(`RX_DMEM_LAT + 1);

  logic [CNT_W-1:0] count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (start_i) begin
      count_r <= CNT_W'(`RX_DMEM_LAT);
    end else if (count_r != '0) begin
      count_r <= count_r - 1'b1;
    end
  end

  assign done_o = (count_r == CNT_W'(1));

  // controller must wait for done before starting again
  a_no_restart_busy: assert property (
    @(posedge clk_i) disable iff (reset_i) start_i |-> (count_r == '0)
  ) else $error("wait timer restarted while busy");

endmodule

// File: design/rx_fsm.sv
// one request at a time; non memory requests are acked in the first valid cycle
// data memory requests wait for the timer, then ack and strobe the bank together
`include "rx_macros.svh"

module rx_fsm (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    v_i,
  input  logic                    w_i,
  input  rx_ctrl_pkg::region_e    region_i,
  input  logic                    timer_done_i,
  output logic                    yumi_o,
  output logic                    timer_start_o,
  output logic                    csr_we_o,
  output logic                    dmem_v_o,
  output logic                    dmem_w_o,
  output logic                    icache_we_o,
  output rx_ctrl_pkg::resp_sel_e  resp_sel_o
);

  rx_ctrl_pkg::rx_state_e state_r;
  rx_ctrl_pkg::rx_state_e state_n;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= rx_ctrl_pkg::ST_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  always_comb begin
    state_n       = state_r;
    yumi_o        = 1'b0;
    timer_start_o = 1'b0;
    csr_we_o      = 1'b0;
    dmem_v_o      = 1'b0;
    dmem_w_o      = 1'b0;
    icache_we_o   = 1'b0;
    resp_sel_o    = rx_ctrl_pkg::RS_NONE;

    case (state_r)
      rx_ctrl_pkg::ST_IDLE: begin
        if (v_i) begin
          case (region_i)
            rx_ctrl_pkg::REG_DMEM: begin
              timer_start_o = 1'b1;
              state_n       = rx_ctrl_pkg::ST_DMEM_WAIT;
            end
            rx_ctrl_pkg::REG_ICACHE: begin
              yumi_o      = 1'b1;
              icache_we_o = w_i;
              // instruction store is write only
              resp_sel_o  = w_i ? rx_ctrl_pkg::RS_ZERO : rx_ctrl_pkg::RS_INVALID;
            end
            rx_ctrl_pkg::REG_CSR: begin
              yumi_o     = 1'b1;
              csr_we_o   = w_i;
              resp_sel_o = w_i ? rx_ctrl_pkg::RS_ZERO : rx_ctrl_pkg::RS_CSR;
            end
            default: begin
              yumi_o     = 1'b1;
              resp_sel_o = rx_ctrl_pkg::RS_INVALID;
            end
          endcase
        end
      end

      rx_ctrl_pkg::ST_DMEM_WAIT: begin
        // request fields are still held by the requester here
        if (timer_done_i) begin
          yumi_o     = 1'b1;
          dmem_v_o   = 1'b1;
          dmem_w_o   = w_i;
          resp_sel_o = w_i ? rx_ctrl_pkg::RS_ZERO : rx_ctrl_pkg::RS_DMEM;
          state_n    = rx_ctrl_pkg::ST_IDLE;
        end
      end

      default: state_n = rx_ctrl_pkg::ST_IDLE;
    endcase
  end

  a_yumi_needs_valid: assert property (
    @(posedge clk_i) disable iff (reset_i) yumi_o |-> v_i
  ) else $error("yumi without valid request");

  // requester holds valid until it is taken
  a_valid_held: assert property (
    @(posedge clk_i) disable iff (reset_i) (v_i && !yumi_o) |=> v_i
  ) else $error("valid dropped before yumi");

endmodule

// File: design/rx_response.sv
// response one cycle after the accepting edge, no back-pressure
// the csr word is captured at the same edge as the source
`include "rx_macros.svh"

module rx_response (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  rx_ctrl_pkg::resp_sel_e  sel_i,
  input  rx_types_pkg::data_t     csr_rdata_i,
  input  rx_types_pkg::data_t     dmem_rdata_i,
  output logic                    returning_v_o,
  output rx_types_pkg::data_t     returning_data_o
);

  rx_ctrl_pkg::resp_sel_e sel_r;
  rx_types_pkg::data_t    csr_rdata_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_r <= rx_ctrl_pkg::RS_NONE;
    end else begin
      sel_r <= sel_i;
    end
  end

  always_ff @(posedge clk_i) begin
    csr_rdata_r <= csr_rdata_i;
  end

  assign returning_v_o = (sel_r != rx_ctrl_pkg::RS_NONE);

  always_comb begin
    case (sel_r)
      rx_ctrl_pkg::RS_DMEM:    returning_data_o = dmem_rdata_i;
      rx_ctrl_pkg::RS_CSR:     returning_data_o = csr_rdata_r;
      rx_ctrl_pkg::RS_INVALID: returning_data_o = `RX_INVALID_DATA;
      default:                 returning_data_o = '0;
    endcase
  end

endmodule

// File: design/tile_rx_top.sv
// receive endpoint of one tile: decode, control, storage and response
// requester holds its fields until yumi_o, one response per request
`include "rx_macros.svh"

module tile_rx_top (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    v_i,
  input  logic                    w_i,
  input  rx_types_pkg::addr_t     addr_i,
  input  rx_types_pkg::data_t     data_i,
  input  rx_types_pkg::mask_t     mask_i,
  output logic                    yumi_o,
  output logic                    returning_v_o,
  output rx_types_pkg::data_t     returning_data_o,
  input  rx_types_pkg::pc_t       fetch_pc_i,
  output rx_types_pkg::data_t     fetch_instr_o,
  output logic                    freeze_o,
  output rx_types_pkg::coord_x_t  tgo_x_o,
  output rx_types_pkg::coord_y_t  tgo_y_o,
  output rx_types_pkg::pc_t       pc_init_val_o
);

  rx_ctrl_pkg::region_e   region;
  rx_ctrl_pkg::csr_idx_e  csr_idx;
  rx_ctrl_pkg::resp_sel_e resp_sel;

  logic timer_start;
  logic timer_done;
  logic csr_we;
  logic dmem_v;
  logic dmem_w;
  logic icache_we;

  rx_types_pkg::data_t csr_rdata;
  rx_types_pkg::data_t dmem_rdata;

  rx_addr_decode decode_i (
    .addr_i    (addr_i),
    .region_o  (region),
    .csr_idx_o (csr_idx)
  );

  rx_fsm fsm_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .v_i           (v_i),
    .w_i           (w_i),
    .region_i      (region),
    .timer_done_i  (timer_done),
    .yumi_o        (yumi_o),
    .timer_start_o (timer_start),
    .csr_we_o      (csr_we),
    .dmem_v_o      (dmem_v),
    .dmem_w_o      (dmem_w),
    .icache_we_o   (icache_we),
    .resp_sel_o    (resp_sel)
  );

  rx_wait_timer timer_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (timer_start),
    .done_o  (timer_done)
  );

  csr_regs csr_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .we_i          (csr_we),
    .idx_i         (csr_idx),
    .wdata_i       (data_i),
    .rdata_o       (csr_rdata),
    .freeze_o      (freeze_o),
    .tgo_x_o       (tgo_x_o),
    .tgo_y_o       (tgo_y_o),
    .pc_init_val_o (pc_init_val_o)
  );

  dmem_bank dmem_i (
    .clk_i   (clk_i),
    .v_i     (dmem_v),
    .w_i     (dmem_w),
    .addr_i  (addr_i[`RX_DMEM_ADDR_WIDTH-1:0]),
    .mask_i  (mask_i),
    .wdata_i (data_i),
    .rdata_o (dmem_rdata)
  );

  icache_store icache_i (
    .clk_i         (clk_i),
    .we_i          (icache_we),
    .wpc_i         (addr_i[`RX_PC_WIDTH-1:0]),
    .winstr_i      (data_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_instr_o (fetch_instr_o)
  );

  rx_response resp_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .sel_i            (resp_sel),
    .csr_rdata_i      (csr_rdata),
    .dmem_rdata_i     (dmem_rdata),
    .returning_v_o    (returning_v_o),
    .returning_data_o (returning_data_o)
  );

endmodule

// File: dv/tile_rx_tb.sv
// random requests against shadow copies of dmem, instruction store and control regs
// every dmem word is filled first, so reads never see unwritten data
`include "rx_macros.svh"

module tile_rx_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_FILL = `RX_DMEM_WORDS;
  localparam int N_RAND = 200;
  localparam int N_SMALL = 40;
  localparam int N_PC = 2 ** `RX_PC_WIDTH;
  localparam int NUM_REQ = N_FILL + N_RAND + 3 * N_SMALL + 36;
  localparam int CYCLE_LIMIT = NUM_REQ * (`RX_DMEM_LAT + 4) + N_PC + 200;

  logic                   clk_i;
  logic                   reset_i;
  logic                   v_i;
  logic                   w_i;
  rx_types_pkg::addr_t    addr_i;
  rx_types_pkg::data_t    data_i;
  rx_types_pkg::mask_t    mask_i;
  rx_types_pkg::pc_t      fetch_pc_i;
  logic                   yumi_o;
  logic                   returning_v_o;
  rx_types_pkg::data_t    returning_data_o;
  rx_types_pkg::data_t    fetch_instr_o;
  logic                   freeze_o;
  rx_types_pkg::coord_x_t tgo_x_o;
  rx_types_pkg::coord_y_t tgo_y_o;
  rx_types_pkg::pc_t      pc_init_val_o;

  // reference model state
  rx_types_pkg::data_t    sh_dmem [`RX_DMEM_WORDS];
  rx_types_pkg::data_t    sh_imem [N_PC];
  logic [N_PC-1:0]        imem_written;
  logic                   sh_freeze;
  rx_types_pkg::coord_x_t sh_tgo_x;
  rx_types_pkg::coord_y_t sh_tgo_y;
  rx_types_pkg::pc_t      sh_pc_init;
  rx_types_pkg::data_t    exp_resp;
  rx_types_pkg::data_t    exp_resp_q;
  rx_types_pkg::data_t    exp_fetch;
  logic                   exp_dmem;
  logic                   req_start;
  logic                   accepted_q;
  logic [31:0]            csr_word_dut;
  logic [31:0]            csr_word_exp;
  string                  test_name;
  integer                 seed;
  int                     cycle_cnt;

  tile_rx_top dut_i (.*);

  always #5 clk_i = ~clk_i;

  assign csr_word_dut = 32'({freeze_o, tgo_x_o, tgo_y_o, pc_init_val_o});
  assign csr_word_exp = 32'({sh_freeze, sh_tgo_x, sh_tgo_y, sh_pc_init});
  assign exp_fetch = sh_imem[fetch_pc_i];

  task automatic stop_failed();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(string check, rx_types_pkg::data_t exp, rx_types_pkg::data_t act);
    $display("Mismatch in %s (%s): expected %h, actual %h", test_name, check, exp, act);
    stop_failed();
  endtask

  // address map as the endpoint documents it
  function automatic rx_ctrl_pkg::region_e region_of(rx_types_pkg::addr_t a);
    if (a[15:9] == '0 && a[8]) return rx_ctrl_pkg::REG_DMEM;
    if (a[15:7] == '0 && a[6]) return rx_ctrl_pkg::REG_ICACHE;
    if (a[15:14] == '0 && a[13] && a[12:2] == '0) return rx_ctrl_pkg::REG_CSR;
    return rx_ctrl_pkg::REG_INVALID;
  endfunction

  function automatic rx_types_pkg::data_t expected_resp(logic w, rx_types_pkg::addr_t a);
    rx_types_pkg::data_t word;
    word = '0;
    if (region_of(a) == rx_ctrl_pkg::REG_INVALID) begin
      word = `RX_INVALID_DATA;
    end else if (!w) begin
      case (region_of(a))
        rx_ctrl_pkg::REG_DMEM: word = sh_dmem[a[7:0]];
        rx_ctrl_pkg::REG_CSR: begin
          case (a[1:0])
            2'd0: word[0] = sh_freeze;
            2'd1: word[3:0] = sh_tgo_x;
            2'd2: word[3:0] = sh_tgo_y;
            default: word[7:2] = sh_pc_init;
          endcase
        end
        default: word = `RX_INVALID_DATA;
      endcase
    end
    return word;
  endfunction

  task automatic apply_write(rx_types_pkg::addr_t a, rx_types_pkg::data_t d,
                             rx_types_pkg::mask_t m);
    case (region_of(a))
      rx_ctrl_pkg::REG_DMEM: begin
        for (int b = 0; b < 4; b++) begin
          if (m[b]) sh_dmem[a[7:0]][8*b +: 8] = d[8*b +: 8];
        end
      end
      rx_ctrl_pkg::REG_ICACHE: begin
        sh_imem[a[5:0]] = d;
        imem_written[a[5:0]] = 1'b1;
        fetch_pc_i = a[5:0];
      end
      rx_ctrl_pkg::REG_CSR: begin
        case (a[1:0])
          2'd0: sh_freeze = d[0];
          2'd1: sh_tgo_x = d[3:0];
          2'd2: sh_tgo_y = d[3:0];
          default: sh_pc_init = d[7:2];
        endcase
      end
      default: ;
    endcase
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send_req(logic w, rx_types_pkg::addr_t a, rx_types_pkg::data_t d,
                          rx_types_pkg::mask_t m);
    v_i = 1'b1;
    w_i = w;
    addr_i = a;
    data_i = d;
    mask_i = (m == '0) ? 4'h1 : m;
    exp_resp = expected_resp(w, a);
    exp_dmem = (region_of(a) == rx_ctrl_pkg::REG_DMEM);
    req_start = 1'b1;
    @(negedge clk_i);
    req_start = 1'b0;
    while (!accepted_q) @(negedge clk_i);
    if (w) apply_write(a, d, mask_i);
    v_i = 1'b0;
    // sometimes a gap, otherwise back to back
    if ($random(seed) & 1) @(negedge clk_i);
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (reset_i) begin
      accepted_q <= 1'b0;
    end else begin
      accepted_q <= v_i && yumi_o;
      if (v_i && yumi_o) exp_resp_q <= exp_resp;
    end
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_failed();
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    $fell(reset_i) |-> !yumi_o && !returning_v_o)
    else report_mismatch("idle after reset", '0,
                         32'({$sampled(yumi_o), $sampled(returning_v_o)}));
  a_csr_outputs: assert property (@(posedge clk_i) disable iff (reset_i)
    csr_word_dut == csr_word_exp)
    else report_mismatch("csr outputs", $sampled(csr_word_exp), $sampled(csr_word_dut));
  a_resp_timing: assert property (@(posedge clk_i) disable iff (reset_i)
    returning_v_o == accepted_q)
    else report_mismatch("response valid", 32'($sampled(accepted_q)),
                         32'($sampled(returning_v_o)));
  a_resp_data: assert property (@(posedge clk_i) disable iff (reset_i)
    returning_v_o |-> returning_data_o == exp_resp_q)
    else report_mismatch("response data", $sampled(exp_resp_q), $sampled(returning_data_o));
  a_dmem_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    req_start && exp_dmem |-> !yumi_o [*`RX_DMEM_LAT] ##1 yumi_o)
    else begin
      $display("dmem request in %s not accepted after the memory latency", test_name);
      stop_failed();
    end
  a_fast_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    req_start && !exp_dmem |-> yumi_o)
    else begin
      $display("non-memory request in %s not accepted in its first cycle", test_name);
      stop_failed();
    end
  a_fetch: assert property (@(posedge clk_i) disable iff (reset_i)
    imem_written[fetch_pc_i] |-> fetch_instr_o == exp_fetch)
    else report_mismatch("fetch word", $sampled(exp_fetch), $sampled(fetch_instr_o));

  initial begin
    logic [31:0] r;
    seed = 32'h2769;
    cycle_cnt = 0;
    clk_i = 1'b0;
    reset_i = 1'b1;
    v_i = 1'b0;
    w_i = 1'b0;
    addr_i = '0;
    data_i = '0;
    mask_i = '0;
    fetch_pc_i = '0;
    exp_resp = '0;
    exp_resp_q = '0;
    exp_dmem = 1'b0;
    req_start = 1'b0;
    imem_written = '0;
    sh_freeze = 1'(`RX_FREEZE_INIT);
    sh_tgo_x = `RX_X_WIDTH'(`RX_TGO_X_INIT);
    sh_tgo_y = `RX_Y_WIDTH'(`RX_TGO_Y_INIT);
    sh_pc_init = `RX_PC_WIDTH'(`RX_PC_INIT);
    test_name = "reset";
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);

    test_name = "dmem_fill";
    for (int i = 0; i < N_FILL; i++) begin
      r = i;
      send_req(1'b1, {8'h01, r[7:0]},
               {~r[7:0], r[7:0] ^ 8'h5a, r[7:0] + 8'h31, r[7:0]}, 4'hf);
    end
    test_name = "dmem_random";
    for (int i = 0; i < N_RAND; i++) begin
      r = $random(seed);
      send_req(r[16], {8'h01, r[7:0]}, $random(seed), r[11:8]);
    end
    test_name = "csr";
    for (int i = 0; i < N_SMALL; i++) begin
      r = $random(seed);
      send_req(r[16] | r[17], {14'h0800, r[1:0]}, $random(seed), 4'hf);
    end
    test_name = "icache";
    for (int i = 0; i < N_SMALL; i++) begin
      r = $random(seed);
      send_req(r[16] | r[17], {10'h001, r[5:0]}, $random(seed), 4'hf);
    end
    test_name = "invalid";
    for (int i = 0; i < N_SMALL; i++) begin
      r = $random(seed);
      case (i % 3)
        0: send_req(r[16], {3'b001, r[12:2] | 11'h1, r[1:0]}, $random(seed), r[27:24]);
        1: send_req(r[16], {1'b1, r[14:0]}, $random(seed), r[27:24]);
        default: send_req(r[16], r[15:0], $random(seed), r[27:24]);
      endcase
    end
    test_name = "recheck";
    for (int i = 0; i < 36; i++) begin
      r = $random(seed);
      if (i < 32) send_req(1'b0, {8'h01, r[7:0]}, '0, 4'hf);
      else send_req(1'b0, {14'h0800, 2'(i)}, '0, 4'hf);
    end

    // every written instruction entry must still hold its last word
    test_name = "fetch_sweep";
    for (int p = 0; p < N_PC; p++) begin
      fetch_pc_i = rx_types_pkg::pc_t'(p);
      @(negedge clk_i);
    end

    repeat (3) @(negedge clk_i);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: tb.f
+incdir+common
common/rx_types_pkg.sv
common/rx_ctrl_pkg.sv
design/rx_addr_decode.sv
design/csr_regs.sv
dmem/dmem_bank.sv
design/icache_store.sv
design/rx_wait_timer.sv
design/rx_fsm.sv
design/rx_response.sv
design/tile_rx_top.sv
dv/tile_rx_tb.sv
